// File: build.f
hw/lcc_trans_pkg.sv
hw/lcc_unlock_decode.sv
hw/lcc_st_translator_fsm.sv
hw/lcc_dbg_enable_gen.sv
hw/lcc_st_trans_top.sv
testbench/lcc_st_trans_sva.sv
testbench/tb_lcc_st_trans.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run with Verilator, then decide pass or fail from the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_lcc_st_trans \
  -f build.f -Mdir obj_dir -o sim_tb > sim.log 2>&1 \
  && ./obj_dir/sim_tb >> sim.log 2>&1 \
  || echo "Test FAILED" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0

// File: testbench/tb_lcc_st_trans.sv
module tb_lcc_st_trans;

  localparam int unsigned LevelWidth = 64;
  localparam int ClkPeriod = 8;
  localparam int ResetCycles = 10;
  localparam int TestCycles = 300;
  localparam int NumTests = 6;
  // Summed test lengths, the reset and a margin
  localparam int WatchdogTime = (NumTests * (TestCycles + 1) + ResetCycles + 200) * ClkPeriod;

  logic                           clk_i;
  logic                           rst_ni;
  lcc_trans_pkg::otp_lc_data_t    otp_data;
  lcc_trans_pkg::lc_otp_req_t     lc_req;
  lcc_trans_pkg::lc_tx_t          lc_dft_en;
  lcc_trans_pkg::lc_tx_t          lc_hw_debug_en;
  logic                           state_error;
  logic                           volatile_unlock;
  logic                           manuf_enable;
  logic                           warm_warn;
  logic [LevelWidth-1:0]          unlock_level;
  logic [LevelWidth-1:0]          dft_mask;
  logic [LevelWidth-1:0]          dbg_mask;
  logic [LevelWidth-1:0]          cltap_mask;
  logic                           soc_dft_en;
  logic                           soc_hw_debug_en;
  lcc_trans_pkg::lc_state_e       static_state;
  lcc_trans_pkg::security_state_t sec_state;

  // Model state
  lcc_trans_pkg::translator_state_e m_state;
  lcc_trans_pkg::lc_state_e         m_static;
  lcc_trans_pkg::security_state_t   m_sec;
  logic                             m_dft_en;
  logic                             m_hw_debug_en;
  logic                             exp_scrap;
  logic                             exp_force;
  logic                             exp_dft_unlock;
  logic                             exp_hw_unlock;
  logic                             exp_prod_unlock;

  int mismatches;
  int tests_passed;
  int tests_failed;

  lcc_st_trans_top #(
    .DbgLevelWidth(LevelWidth)
  ) u_dut (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .otp_data_i             (otp_data),
    .lc_otp_req_i           (lc_req),
    .lc_dft_en_i            (lc_dft_en),
    .lc_hw_debug_en_i       (lc_hw_debug_en),
    .state_error_i          (state_error),
    .volatile_raw_unlock_i  (volatile_unlock),
    .dbg_manuf_enable_i     (manuf_enable),
    .early_warm_reset_warn_i(warm_warn),
    .dbg_unlock_level_i     (unlock_level),
    .dft_en_mask_i          (dft_mask),
    .dbg_unlock_mask_i      (dbg_mask),
    .cltap_unlock_mask_i    (cltap_mask),
    .soc_dft_en_o           (soc_dft_en),
    .soc_hw_debug_en_o      (soc_hw_debug_en),
    .otp_static_state_o     (static_state),
    .security_state_o       (sec_state)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogTime);
    $display("Watchdog expired, the tests did not finish in the expected time");
    $display("Test FAILED");
    $finish;
  end

  // ------------------------------
  // Reference model
  // ------------------------------

  // Target of the IDLE decode for one lifecycle code
  function automatic lcc_trans_pkg::translator_state_e decode_static(logic [4:0] code);
    if (code == lcc_trans_pkg::LcStScrap || code == lcc_trans_pkg::LcStRaw) begin
      return lcc_trans_pkg::NON_DEBUG;
    end
    if (code >= 5'd9 && code <= 5'd15) begin
      return lcc_trans_pkg::NON_DEBUG;
    end
    if (code >= 5'd1 && code <= 5'd8) begin
      return lcc_trans_pkg::UNPROV_DEBUG;
    end
    if (code == 5'd16) begin
      return lcc_trans_pkg::MANUF_NON_DEBUG;
    end
    if (code == 5'd17 || code == 5'd18) begin
      return lcc_trans_pkg::PROD_NON_DEBUG;
    end
    if (code == 5'd19) begin
      return lcc_trans_pkg::PROD_DEBUG;
    end
    return lcc_trans_pkg::IDLE;
  endfunction

  function automatic lcc_trans_pkg::translator_state_e predict_next(
    lcc_trans_pkg::translator_state_e st, logic [4:0] code, logic force_lock,
    logic vol, logic manuf, logic prod_unlock);
    if (st == lcc_trans_pkg::RESET) begin
      return lcc_trans_pkg::IDLE;
    end
    if (st == lcc_trans_pkg::IDLE) begin
      return force_lock ? lcc_trans_pkg::NON_DEBUG : decode_static(code);
    end
    if (st == lcc_trans_pkg::NON_DEBUG) begin
      return (vol && !force_lock) ? lcc_trans_pkg::UNPROV_DEBUG : lcc_trans_pkg::NON_DEBUG;
    end
    if (force_lock) begin
      return lcc_trans_pkg::NON_DEBUG;
    end
    if (st == lcc_trans_pkg::MANUF_NON_DEBUG && manuf) begin
      return lcc_trans_pkg::MANUF_DEBUG;
    end
    if (st == lcc_trans_pkg::PROD_NON_DEBUG && prod_unlock) begin
      return lcc_trans_pkg::PROD_DEBUG;
    end
    return st;
  endfunction

  function automatic lcc_trans_pkg::security_state_t predict_output(
    lcc_trans_pkg::translator_state_e st, logic force_lock);
    lcc_trans_pkg::security_state_t s;
    s = lcc_trans_pkg::SecStateDefault;
    if (!force_lock) begin
      case (st)
        lcc_trans_pkg::UNPROV_DEBUG: begin
          s = '{device_lifecycle: lcc_trans_pkg::DEVICE_UNPROVISIONED, debug_locked: 1'b0};
        end
        lcc_trans_pkg::MANUF_NON_DEBUG: begin
          s = '{device_lifecycle: lcc_trans_pkg::DEVICE_MANUFACTURING, debug_locked: 1'b1};
        end
        lcc_trans_pkg::MANUF_DEBUG: begin
          s = '{device_lifecycle: lcc_trans_pkg::DEVICE_MANUFACTURING, debug_locked: 1'b0};
        end
        lcc_trans_pkg::PROD_DEBUG: begin
          s = '{device_lifecycle: lcc_trans_pkg::DEVICE_PRODUCTION, debug_locked: 1'b0};
        end
        default: begin
        end
      endcase
    end
    return s;
  endfunction

  assign exp_scrap       = lc_req.req && (lc_req.state == lcc_trans_pkg::LcStScrap);
  assign exp_force       = exp_scrap || state_error;
  assign exp_dft_unlock  = (|(unlock_level & dft_mask)) || (manuf_enable && dft_mask[0]);
  assign exp_hw_unlock   = |(unlock_level & cltap_mask);
  assign exp_prod_unlock = |(unlock_level & dbg_mask);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni || !otp_data.valid) begin
      m_state       <= lcc_trans_pkg::RESET;
      m_static      <= lcc_trans_pkg::LcStRaw;
      m_sec         <= lcc_trans_pkg::SecStateDefault;
      m_dft_en      <= 1'b0;
      m_hw_debug_en <= 1'b0;
    end else begin
      m_state  <= predict_next(m_state, m_static, exp_force, volatile_unlock,
                               manuf_enable, exp_prod_unlock);
      m_static <= otp_data.state;
      m_sec    <= warm_warn ? lcc_trans_pkg::SecStateDefault
                            : predict_output(m_state, exp_force);
      m_dft_en      <= ((lc_dft_en == lcc_trans_pkg::LcTxOn) || exp_dft_unlock) && !exp_scrap;
      m_hw_debug_en <= ((lc_hw_debug_en == lcc_trans_pkg::LcTxOn) || exp_hw_unlock) &&
                       !exp_scrap;
    end
  end

  // ------------------------------
  // Stimulus helpers and checks
  // ------------------------------

  function automatic bit chance(int pct);
    return ($urandom_range(99, 0) < pct);
  endfunction

  function automatic logic [LevelWidth-1:0] random_mask();
    logic [LevelWidth-1:0] v;
    for (int k = 0; k < LevelWidth; k++) begin
      v[k] = 1'($urandom_range(1, 0));
    end
    return v;
  endfunction

  // Zero or one bit set, so overlaps with the masks stay occasional
  function automatic logic [LevelWidth-1:0] random_level(int pct);
    logic [LevelWidth-1:0] v;
    v = '0;
    if (chance(pct)) begin
      v[$urandom_range(LevelWidth - 1, 0)] = 1'b1;
    end
    return v;
  endfunction

  function automatic lcc_trans_pkg::lc_state_e pick_state(bit biased);
    logic [4:0] code;
    code = 5'($urandom_range(31, 0));
    if (biased && chance(60)) begin
      case ($urandom_range(3, 0))
        0:       code = lcc_trans_pkg::LcStRaw;
        1:       code = lcc_trans_pkg::LcStDev;
        2:       code = lcc_trans_pkg::LcStProd;
        default: code = lcc_trans_pkg::LcStProdEnd;
      endcase
    end
    return lcc_trans_pkg::lc_state_e'(code);
  endfunction

  task automatic compare_outputs();
    assert (sec_state === m_sec) else begin
      $display("[FAIL] security_state_o expected %h got %h", m_sec, sec_state);
      mismatches++;
    end
    assert (static_state === m_static) else begin
      $display("[FAIL] otp_static_state_o expected %h got %h", m_static, static_state);
      mismatches++;
    end
    assert (soc_dft_en === m_dft_en) else begin
      $display("[FAIL] soc_dft_en_o expected %h got %h", m_dft_en, soc_dft_en);
      mismatches++;
    end
    assert (soc_hw_debug_en === m_hw_debug_en) else begin
      $display("[FAIL] soc_hw_debug_en_o expected %h got %h", m_hw_debug_en, soc_hw_debug_en);
      mismatches++;
    end
  endtask

  // Probabilities are in percent per cycle
  task automatic run_test(input string name, input int p_invalid, input int p_err,
                          input int p_scrap, input int p_vol, input int p_warn,
                          input int p_manuf, input int p_on, input int p_overlap,
                          input bit biased);
    int errs_before;
    errs_before = mismatches;
    dft_mask    = random_mask();
    dbg_mask    = random_mask();
    cltap_mask  = random_mask();
    for (int i = 0; i < TestCycles; i++) begin
      @(negedge clk_i);
      compare_outputs();
      if (!otp_data.valid || chance(5)) begin
        otp_data.state = pick_state(biased);
      end
      otp_data.valid  = !chance(p_invalid);
      lc_req.req      = chance(p_scrap);
      lc_req.state    = chance(70) ? lcc_trans_pkg::LcStScrap : pick_state(1'b0);
      state_error     = chance(p_err);
      volatile_unlock = chance(p_vol);
      warm_warn       = chance(p_warn);
      manuf_enable    = chance(p_manuf);
      lc_dft_en       = chance(p_on) ? lcc_trans_pkg::LcTxOn : 4'($urandom_range(15, 0));
      lc_hw_debug_en  = chance(p_on) ? lcc_trans_pkg::LcTxOn : 4'($urandom_range(15, 0));
      unlock_level    = random_level(p_overlap);
    end
    @(negedge clk_i);
    compare_outputs();
    if (mismatches == errs_before) begin
      tests_passed++;
      $display("%s: done, %0d cycles, no mismatches", name, TestCycles);
    end else begin
      tests_failed++;
      $display("%s: done, %0d mismatches", name, mismatches - errs_before);
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    void'($urandom(32'h90e1));
    rst_ni          = 1'b0;
    otp_data        = '{valid: 1'b0, state: lcc_trans_pkg::LcStRaw};
    lc_req          = '{req: 1'b0, state: lcc_trans_pkg::LcStRaw};
    lc_dft_en       = '0;
    lc_hw_debug_en  = '0;
    state_error     = 1'b0;
    volatile_unlock = 1'b0;
    manuf_enable    = 1'b0;
    warm_warn       = 1'b0;
    unlock_level    = '0;
    dft_mask        = '0;
    dbg_mask        = '0;
    cltap_mask      = '0;
    mismatches      = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;

    run_test("reset_valid",   25, 3, 3, 5, 3, 10, 30, 20, 1'b0);
    run_test("static_decode",  4, 0, 0, 0, 0,  0,  0,  0, 1'b0);
    run_test("unlocks",        3, 0, 0, 6, 0,  8,  0, 15, 1'b1);
    run_test("forcing",        3, 4, 4, 4, 0,  8, 40, 15, 1'b1);
    run_test("enables",        5, 1, 3, 0, 0, 10, 50, 40, 1'b0);
    run_test("warm_reset",     3, 1, 1, 4, 15, 8, 20, 15, 1'b1);

    $display("Summary: %0d tests passed, %0d tests failed, %0d mismatches",
             tests_passed, tests_failed, mismatches);
    if (tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/lcc_st_trans_sva.sv
module lcc_st_trans_sva (
  input logic                           clk_i,
  input logic                           rst_ni,
  input lcc_trans_pkg::otp_lc_data_t    otp_data_i,
  input lcc_trans_pkg::lc_otp_req_t     lc_otp_req_i,
  input logic                           dbg_manuf_enable_i,
  input logic                           soc_dft_en_i,
  input logic                           soc_hw_debug_en_i,
  input lcc_trans_pkg::security_state_t security_state_i
);

  logic manuf_seen;

  // Set by the manufacturing enable and cleared whenever invalid fuse data resets the FSM
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      manuf_seen <= 1'b0;
    end else if (!otp_data_i.valid) begin
      manuf_seen <= 1'b0;
    end else if (dbg_manuf_enable_i) begin
      manuf_seen <= 1'b1;
    end
  end

  // ------------------------------
  // Properties
  // ------------------------------

  a_enables_after_reset: assert property (@(posedge clk_i)
    !rst_ni |=> (!soc_dft_en_i && !soc_hw_debug_en_i))
    else $error("SoC enables set right after reset");

  a_scrap_clears_enables: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (otp_data_i.valid && lc_otp_req_i.req && (lc_otp_req_i.state == lcc_trans_pkg::LcStScrap))
    |=> (!soc_dft_en_i && !soc_hw_debug_en_i))
    else $error("SoC enables still set one cycle after a scrap request");

  a_invalid_gives_default: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !otp_data_i.valid |=> (security_state_i == lcc_trans_pkg::SecStateDefault))
    else $error("Security state not locked one cycle after fuse data went invalid");

  a_manuf_unlock_needs_enable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((security_state_i.device_lifecycle == lcc_trans_pkg::DEVICE_MANUFACTURING) &&
     !security_state_i.debug_locked) |-> manuf_seen)
    else $error("Manufacturing debug unlocked without the manufacturing enable");

endmodule

bind lcc_st_trans_top lcc_st_trans_sva u_sva (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .otp_data_i        (otp_data_i),
  .lc_otp_req_i      (lc_otp_req_i),
  .dbg_manuf_enable_i(dbg_manuf_enable_i),
  .soc_dft_en_i      (soc_dft_en_o),
  .soc_hw_debug_en_i (soc_hw_debug_en_o),
  .security_state_i  (security_state_o)
);

// File: hw/lcc_st_trans_top.sv
module lcc_st_trans_top #(
  parameter int unsigned DbgLevelWidth = 64
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  lcc_trans_pkg::otp_lc_data_t    otp_data_i,
  input  lcc_trans_pkg::lc_otp_req_t     lc_otp_req_i,
  input  lcc_trans_pkg::lc_tx_t          lc_dft_en_i,
  input  lcc_trans_pkg::lc_tx_t          lc_hw_debug_en_i,
  input  logic                           state_error_i,
  input  logic                           volatile_raw_unlock_i,
  input  logic                           dbg_manuf_enable_i,
  input  logic                           early_warm_reset_warn_i,
  input  logic [DbgLevelWidth-1:0]       dbg_unlock_level_i,
  input  logic [DbgLevelWidth-1:0]       dft_en_mask_i,
  input  logic [DbgLevelWidth-1:0]       dbg_unlock_mask_i,
  input  logic [DbgLevelWidth-1:0]       cltap_unlock_mask_i,
  output logic                           soc_dft_en_o,
  output logic                           soc_hw_debug_en_o,
  output lcc_trans_pkg::lc_state_e       otp_static_state_o,
  output lcc_trans_pkg::security_state_t security_state_o
);

  lcc_trans_pkg::unlock_req_t unlock_req;
  logic                       scrap_req;

  // SoC unlock level reduced against the masks
  lcc_unlock_decode #(
    .DbgLevelWidth(DbgLevelWidth)
  ) u_unlock_decode (
    .dbg_unlock_level_i (dbg_unlock_level_i),
    .dbg_manuf_enable_i (dbg_manuf_enable_i),
    .dft_en_mask_i      (dft_en_mask_i),
    .dbg_unlock_mask_i  (dbg_unlock_mask_i),
    .cltap_unlock_mask_i(cltap_unlock_mask_i),
    .unlock_req_o       (unlock_req)
  );

  // Security state translation, also the single source of the scrap request
  lcc_st_translator_fsm u_translator_fsm (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .otp_data_i             (otp_data_i),
    .lc_otp_req_i           (lc_otp_req_i),
    .state_error_i          (state_error_i),
    .volatile_raw_unlock_i  (volatile_raw_unlock_i),
    .dbg_manuf_enable_i     (dbg_manuf_enable_i),
    .early_warm_reset_warn_i(early_warm_reset_warn_i),
    .unlock_req_i           (unlock_req),
    .scrap_req_o            (scrap_req),
    .otp_static_state_o     (otp_static_state_o),
    .security_state_o       (security_state_o)
  );

  lcc_dbg_enable_gen u_dbg_enable_gen (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .otp_valid_i      (otp_data_i.valid),
    .lc_dft_en_i      (lc_dft_en_i),
    .lc_hw_debug_en_i (lc_hw_debug_en_i),
    .unlock_req_i     (unlock_req),
    .scrap_req_i      (scrap_req),
    .soc_dft_en_o     (soc_dft_en_o),
    .soc_hw_debug_en_o(soc_hw_debug_en_o)
  );

endmodule

// File: hw/lcc_dbg_enable_gen.sv
module lcc_dbg_enable_gen (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       otp_valid_i,
  input  lcc_trans_pkg::lc_tx_t      lc_dft_en_i,
  input  lcc_trans_pkg::lc_tx_t      lc_hw_debug_en_i,
  input  lcc_trans_pkg::unlock_req_t unlock_req_i,
  input  logic                       scrap_req_i,
  output logic                       soc_dft_en_o,
  output logic                       soc_hw_debug_en_o
);

  logic lc_dft_on;
  logic lc_hw_debug_on;
  logic dft_en_d;
  logic hw_debug_en_d;

  // ------------------------------
  // Enable equations
  // ------------------------------

  // Any pattern other than On is treated as off
  assign lc_dft_on      = (lc_dft_en_i == lcc_trans_pkg::LcTxOn);
  assign lc_hw_debug_on = (lc_hw_debug_en_i == lcc_trans_pkg::LcTxOn);

  // Scrap request overrides both the lifecycle enables and the SoC unlocks
  assign dft_en_d      = (lc_dft_on | unlock_req_i.dft_unlock) & ~scrap_req_i;
  assign hw_debug_en_d = (lc_hw_debug_on | unlock_req_i.hw_dbg_unlock) & ~scrap_req_i;

  // ------------------------------
  // Output registers
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end else if (otp_valid_i) begin
      soc_dft_en_o      <= dft_en_d;
      soc_hw_debug_en_o <= hw_debug_en_d;
    end else begin
      // Without valid fuse data nothing is enabled
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end
  end

endmodule

// File: hw/lcc_st_translator_fsm.sv
module lcc_st_translator_fsm (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  lcc_trans_pkg::otp_lc_data_t      otp_data_i,
  input  lcc_trans_pkg::lc_otp_req_t       lc_otp_req_i,
  input  logic                             state_error_i,
  input  logic                             volatile_raw_unlock_i,
  input  logic                             dbg_manuf_enable_i,
  input  logic                             early_warm_reset_warn_i,
  input  lcc_trans_pkg::unlock_req_t       unlock_req_i,
  output logic                             scrap_req_o,
  output lcc_trans_pkg::lc_state_e         otp_static_state_o,
  output lcc_trans_pkg::security_state_t   security_state_o
);

  lcc_trans_pkg::translator_state_e state_q;
  lcc_trans_pkg::translator_state_e state_d;
  lcc_trans_pkg::security_state_t   sec_state_d;
  logic                             force_lock;

  // ------------------------------
  // Scrap and force detection
  // ------------------------------

  // A program request towards Scrap counts as scrap even before the fuses change
  assign scrap_req_o = lc_otp_req_i.req && (lc_otp_req_i.state == lcc_trans_pkg::LcStScrap);

  assign force_lock = scrap_req_o | state_error_i;

  // ------------------------------
  // Next state and decoded output
  // ------------------------------

  always_comb begin
    state_d     = state_q;
    sec_state_d = lcc_trans_pkg::SecStateDefault;

    case (state_q)
      lcc_trans_pkg::RESET: begin
        state_d = lcc_trans_pkg::IDLE;
      end

      // Decode from the sampled static state, not the live fuse input
      lcc_trans_pkg::IDLE: begin
        if (force_lock || (otp_static_state_o == lcc_trans_pkg::LcStScrap)) begin
          state_d = lcc_trans_pkg::NON_DEBUG;
        end else if (otp_static_state_o inside {lcc_trans_pkg::LcStRaw,
                                                lcc_trans_pkg::LcStTestLocked0,
                                                lcc_trans_pkg::LcStTestLocked1,
                                                lcc_trans_pkg::LcStTestLocked2,
                                                lcc_trans_pkg::LcStTestLocked3,
                                                lcc_trans_pkg::LcStTestLocked4,
                                                lcc_trans_pkg::LcStTestLocked5,
                                                lcc_trans_pkg::LcStTestLocked6}) begin
          state_d = lcc_trans_pkg::NON_DEBUG;
        end else if (otp_static_state_o inside {lcc_trans_pkg::LcStTestUnlocked0,
                                                lcc_trans_pkg::LcStTestUnlocked1,
                                                lcc_trans_pkg::LcStTestUnlocked2,
                                                lcc_trans_pkg::LcStTestUnlocked3,
                                                lcc_trans_pkg::LcStTestUnlocked4,
                                                lcc_trans_pkg::LcStTestUnlocked5,
                                                lcc_trans_pkg::LcStTestUnlocked6,
                                                lcc_trans_pkg::LcStTestUnlocked7}) begin
          state_d = lcc_trans_pkg::UNPROV_DEBUG;
        end else if (otp_static_state_o == lcc_trans_pkg::LcStDev) begin
          state_d = lcc_trans_pkg::MANUF_NON_DEBUG;
        end else if (otp_static_state_o inside {lcc_trans_pkg::LcStProd,
                                                lcc_trans_pkg::LcStProdEnd}) begin
          state_d = lcc_trans_pkg::PROD_NON_DEBUG;
        end else if (otp_static_state_o == lcc_trans_pkg::LcStRma) begin
          state_d = lcc_trans_pkg::PROD_DEBUG;
        end else begin
          // Invalid codes park here with the locked default
          state_d = lcc_trans_pkg::IDLE;
        end
      end

      lcc_trans_pkg::NON_DEBUG: begin
        if (volatile_raw_unlock_i && !force_lock) begin
          state_d = lcc_trans_pkg::UNPROV_DEBUG;
        end
      end

      lcc_trans_pkg::UNPROV_DEBUG: begin
        if (force_lock) begin
          state_d = lcc_trans_pkg::NON_DEBUG;
        end else begin
          sec_state_d.device_lifecycle = lcc_trans_pkg::DEVICE_UNPROVISIONED;
          sec_state_d.debug_locked     = 1'b0;
        end
      end

      lcc_trans_pkg::MANUF_NON_DEBUG: begin
        if (force_lock) begin
          state_d = lcc_trans_pkg::NON_DEBUG;
        end else begin
          if (dbg_manuf_enable_i) begin
            state_d = lcc_trans_pkg::MANUF_DEBUG;
          end
          sec_state_d.device_lifecycle = lcc_trans_pkg::DEVICE_MANUFACTURING;
          sec_state_d.debug_locked     = 1'b1;
        end
      end

      lcc_trans_pkg::MANUF_DEBUG: begin
        if (force_lock) begin
          state_d = lcc_trans_pkg::NON_DEBUG;
        end else begin
          sec_state_d.device_lifecycle = lcc_trans_pkg::DEVICE_MANUFACTURING;
          sec_state_d.debug_locked     = 1'b0;
        end
      end

      lcc_trans_pkg::PROD_NON_DEBUG: begin
        if (force_lock) begin
          state_d = lcc_trans_pkg::NON_DEBUG;
        end else if (unlock_req_i.prod_dbg_unlock) begin
          // Output stays locked in the cycle of the unlock itself
          state_d = lcc_trans_pkg::PROD_DEBUG;
        end
      end

      lcc_trans_pkg::PROD_DEBUG: begin
        if (force_lock) begin
          state_d = lcc_trans_pkg::NON_DEBUG;
        end else begin
          sec_state_d.debug_locked = 1'b0;
        end
      end

      default: begin
        state_d = lcc_trans_pkg::IDLE;
      end
    endcase
  end

  // ------------------------------
  // Registers
  // ------------------------------

  // Valid low returns everything to the reset values on the next edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q            <= lcc_trans_pkg::RESET;
      otp_static_state_o <= lcc_trans_pkg::LcStRaw;
      security_state_o   <= lcc_trans_pkg::SecStateDefault;
    end else if (otp_data_i.valid) begin
      state_q            <= state_d;
      otp_static_state_o <= otp_data_i.state;
      // Warm reset warning locks the output but lets the FSM advance
      if (early_warm_reset_warn_i) begin
        security_state_o <= lcc_trans_pkg::SecStateDefault;
      end else begin
        security_state_o <= sec_state_d;
      end
    end else begin
      state_q            <= lcc_trans_pkg::RESET;
      otp_static_state_o <= lcc_trans_pkg::LcStRaw;
      security_state_o   <= lcc_trans_pkg::SecStateDefault;
    end
  end

endmodule

// File: hw/lcc_unlock_decode.sv
module lcc_unlock_decode #(
  parameter int unsigned DbgLevelWidth = 64
) (
  input  logic [DbgLevelWidth-1:0] dbg_unlock_level_i,
  input  logic                     dbg_manuf_enable_i,
  input  logic [DbgLevelWidth-1:0] dft_en_mask_i,
  input  logic [DbgLevelWidth-1:0] dbg_unlock_mask_i,
  input  logic [DbgLevelWidth-1:0] cltap_unlock_mask_i,
  output lcc_trans_pkg::unlock_req_t unlock_req_o
);

  logic [DbgLevelWidth-1:0] dft_overlap;
  logic [DbgLevelWidth-1:0] cltap_overlap;
  logic [DbgLevelWidth-1:0] prod_overlap;
  logic                     manuf_dft;

  // ------------------------------
  // Level against mask overlaps
  // ------------------------------

  assign dft_overlap   = dbg_unlock_level_i & dft_en_mask_i;
  assign cltap_overlap = dbg_unlock_level_i & cltap_unlock_mask_i;
  assign prod_overlap  = dbg_unlock_level_i & dbg_unlock_mask_i;

  // Manufacturing debug opens DFT only when the SoC allows it in mask bit 0
  assign manuf_dft = dbg_manuf_enable_i & dft_en_mask_i[0];

  // ------------------------------
  // Unlock requests
  // ------------------------------

  assign unlock_req_o.dft_unlock      = (|dft_overlap) | manuf_dft;
  assign unlock_req_o.hw_dbg_unlock   = |cltap_overlap;

  // Gates the move from production locked to production debug in the FSM
  assign unlock_req_o.prod_dbg_unlock = |prod_overlap;

endmodule

// File: hw/lcc_trans_pkg.sv
package lcc_trans_pkg;

  // ------------------------------
  // Lifecycle controller side
  // ------------------------------

  // Lifecycle states as reported by the fuse controller, codes 21 to 31 are invalid
  typedef enum logic [4:0] {
    LcStRaw           = 5'd0,
    LcStTestUnlocked0 = 5'd1,
    LcStTestUnlocked1 = 5'd2,
    LcStTestUnlocked2 = 5'd3,
    LcStTestUnlocked3 = 5'd4,
    LcStTestUnlocked4 = 5'd5,
    LcStTestUnlocked5 = 5'd6,
    LcStTestUnlocked6 = 5'd7,
    LcStTestUnlocked7 = 5'd8,
    LcStTestLocked0   = 5'd9,
    LcStTestLocked1   = 5'd10,
    LcStTestLocked2   = 5'd11,
    LcStTestLocked3   = 5'd12,
    LcStTestLocked4   = 5'd13,
    LcStTestLocked5   = 5'd14,
    LcStTestLocked6   = 5'd15,
    LcStDev           = 5'd16,
    LcStProd          = 5'd17,
    LcStProdEnd       = 5'd18,
    LcStRma           = 5'd19,
    LcStScrap         = 5'd20
  } lc_state_e;

  // Multi-bit enable, only the exact On pattern counts as enabled
  typedef logic [3:0] lc_tx_t;

  parameter lc_tx_t LcTxOn = 4'b0101;

  // Fuse controller data towards the lifecycle controller
  typedef struct packed {
    logic      valid;
    lc_state_e state;
  } otp_lc_data_t;

  // Program request from the lifecycle controller to the fuse controller
  typedef struct packed {
    logic      req;
    lc_state_e state;
  } lc_otp_req_t;

  // ------------------------------
  // Security core side
  // ------------------------------

  typedef enum logic [1:0] {
    DEVICE_UNPROVISIONED = 2'b00,
    DEVICE_MANUFACTURING = 2'b01,
    DEVICE_PRODUCTION    = 2'b11
  } device_lifecycle_e;

  typedef struct packed {
    device_lifecycle_e device_lifecycle;
    logic              debug_locked;
  } security_state_t;

  // Locked production, the safe fallback
  parameter security_state_t SecStateDefault = '{
    device_lifecycle: DEVICE_PRODUCTION,
    debug_locked:     1'b1
  };

  // Unlock requests decoded from the SoC unlock level
  typedef struct packed {
    logic dft_unlock;
    logic hw_dbg_unlock;
    logic prod_dbg_unlock;
  } unlock_req_t;

  typedef enum logic [2:0] {
    RESET,
    IDLE,
    NON_DEBUG,
    UNPROV_DEBUG,
    MANUF_NON_DEBUG,
    MANUF_DEBUG,
    PROD_NON_DEBUG,
    PROD_DEBUG
  } translator_state_e;

endpackage
